//--- keypad_texting.f
logic/keypad_pkg.sv
logic/scan_timer.sv
logic/keypad_scanner.sv
logic/key_debouncer.sv
logic/multitap_control.sv
logic/message_assembler.sv
logic/keypad_control.sv
verification/keypad_control_checker.sv
verification/keypad_control_tb.sv

//--- Makefile
# Verilator build and run for the keypad texting unit
VERILATOR  ?= verilator
TOP        ?= keypad_control_tb
FILELIST   ?= keypad_texting.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall
SIMFLAGS   ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIMFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -q "NO ERRORS" $(LOG); then echo "simulation ended without a verdict"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/keypad_control_tb.sv
`default_nettype none

module keypad_control_tb
    import keypad_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCAN        = 8;
    localparam int SWEEP_CYC   = 4 * SCAN;
    localparam int RESET_CYC   = 8;
    localparam int HOLD_SWEEPS = 4;
    localparam int GAP_SWEEPS  = 3;
    localparam int NUM_ROWS    = 51;
    // each row is 4 sweeps held plus 3 released
    localparam int LIMIT_CYC   = RESET_CYC + NUM_ROWS * 7 * SWEEP_CYC + 400;

    logic     clk = 1'b0;
    logic     rst_n;
    lines_t   readrow;
    lines_t   scancol;
    logic     msg_tx_ctrl;
    message_t msg_1;
    keycode_t held_key;

    // stimulus table, low four characters newest last
    keycode_t    key_tab [NUM_ROWS];
    logic [31:0] exp_tab [NUM_ROWS];
    int          pulse_tab [NUM_ROWS];
    int          n_rows = 0;
    int          errors = 0;
    int          tests = 0;
    int          pulse_cnt = 0;

    keycode_t digit_keys [10] = '{KEY_1, KEY_2, KEY_3, KEY_4, KEY_5,
                                  KEY_6, KEY_7, KEY_8, KEY_9, KEY_0};
    ascii_t   digit_chars [10] = '{"1", "2", "3", "4", "5", "6", "7", "8", "9", "0"};

    always #10 clk = ~clk;

    keypad_control #(
        .scan_ticks (SCAN)
    ) keypad_control_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .readrow     (readrow),
        .scancol     (scancol),
        .msg_tx_ctrl (msg_tx_ctrl),
        .msg_1       (msg_1)
    );

    // keypad model, the held key's row shows up while its column is driven
    assign readrow = ((held_key[3:0] & scancol) != 4'b0000) ? held_key[7:4] : 4'b0000;

    // running count of send pulses
    always @(negedge clk) begin
        if (rst_n && msg_tx_ctrl) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    task automatic add_row(input keycode_t key, input logic [31:0] exp_low, input int pulses);
        key_tab[n_rows]   = key;
        exp_tab[n_rows]   = exp_low;
        pulse_tab[n_rows] = pulses;
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] low;
        // number mode digits, star and hash
        add_row(KEY_1, "   1", 0);
        add_row(KEY_2, "  12", 0);
        add_row(KEY_3, " 123", 0);
        add_row(KEY_STAR, "123*", 0);
        add_row(KEY_0, "23*0", 0);
        add_row(KEY_HASH, "3*0#", 0);
        // letter mode, 2 2 C gives b
        add_row(KEY_B, "3*0#", 0);
        add_row(KEY_2, "3*0#", 0);
        add_row(KEY_2, "3*0#", 0);
        add_row(KEY_C, "*0#b", 0);
        // four taps on 7 reach s
        for (int i = 0; i < 4; i++) begin
            add_row(KEY_7, "*0#b", 0);
        end
        add_row(KEY_C, "0#bs", 0);
        // four taps on 2 wrap back to a
        for (int i = 0; i < 4; i++) begin
            add_row(KEY_2, "0#bs", 0);
        end
        add_row(KEY_C, "#bsa", 0);
        // new key commits the old one
        add_row(KEY_4, "#bsa", 0);
        add_row(KEY_5, "bsag", 0);
        add_row(KEY_C, "sagj", 0);
        add_row(KEY_C, "agj ", 0);
        // shift on, letters go upper case
        add_row(KEY_HASH, "agj ", 0);
        add_row(KEY_9, "agj ", 0);
        add_row(KEY_9, "agj ", 0);
        add_row(KEY_C, "gj X", 0);
        // punctuation ignores shift
        add_row(KEY_1, "gj X", 0);
        add_row(KEY_1, "gj X", 0);
        add_row(KEY_C, "j X_", 0);
        add_row(KEY_A, "j X_", 0);
        // send commits the pending key
        add_row(KEY_3, "j X_", 0);
        add_row(KEY_D, " X_D", 1);
        add_row(KEY_B, " X_D", 1);
        // sixteen digits push everything older out
        low = " X_D";
        for (int i = 0; i < MSG_CHARS; i++) begin
            low = {low[23:0], digit_chars[i % 10]};
            add_row(digit_keys[i % 10], low, 1);
        end
    endtask

    // entered just after a rising edge
    task automatic press_key(input keycode_t key);
        held_key = key;
        repeat (HOLD_SWEEPS * SWEEP_CYC) @(posedge clk);
        #2;
        held_key = KEY_NONE;
        repeat (GAP_SWEEPS * SWEEP_CYC) @(posedge clk);
        #2;
    endtask

    task automatic check_row(input int idx);
        int errs_before;
        errs_before = errors;
        if (msg_1[31:0] !== exp_tab[idx]) begin
            $display("ERR t=%0t msg_1[31:0] expected \"%s\" (%h) got \"%s\" (%h)",
                     $time, exp_tab[idx], exp_tab[idx], msg_1[31:0], msg_1[31:0]);
            errors++;
        end
        if (pulse_cnt != pulse_tab[idx]) begin
            $display("ERR t=%0t msg_tx_ctrl pulses expected %0d got %0d",
                     $time, pulse_tab[idx], pulse_cnt);
            errors++;
        end
        tests++;
        $display("test %0d key %h: %s", tests, key_tab[idx],
                 (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        int errs_before;
        rst_n    = 1'b0;
        held_key = KEY_NONE;
        build_table();
        if (n_rows != NUM_ROWS) begin
            $display("stimulus table holds %0d rows instead of %0d", n_rows, NUM_ROWS);
            errors++;
        end
        repeat (RESET_CYC) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // reset state
        errs_before = errors;
        if (msg_1 !== {MSG_CHARS{" "}}) begin
            $display("ERR t=%0t msg_1 expected \"%s\" got \"%s\"",
                     $time, {MSG_CHARS{" "}}, msg_1);
            errors++;
        end
        if (scancol !== 4'b0001) begin
            $display("ERR t=%0t scancol expected 0001 got %b", $time, scancol);
            errors++;
        end
        if (msg_tx_ctrl !== 1'b0) begin
            $display("ERR t=%0t msg_tx_ctrl expected 0 got %b", $time, msg_tx_ctrl);
            errors++;
        end
        tests++;
        $display("test %0d reset: %s", tests, (errors == errs_before) ? "ok" : "failed");
        for (int r = 0; r < n_rows; r++) begin
            press_key(key_tab[r]);
            check_row(r);
        end
        // whole register after the last sixteen digits
        errs_before = errors;
        if (msg_1 !== "1234567890123456") begin
            $display("ERR t=%0t msg_1 expected \"%s\" got \"%s\"",
                     $time, "1234567890123456", msg_1);
            errors++;
        end
        tests++;
        $display("test %0d full message: %s", tests,
                 (errors == errs_before) ? "ok" : "failed");
        if (keypad_control_inst.checker_inst.assert_fails != 0) begin
            $display("checker saw %0d assertion failures",
                     keypad_control_inst.checker_inst.assert_fails);
            errors += keypad_control_inst.checker_inst.assert_fails;
        end
        $display("%0d tests run, %0d checks failed", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (LIMIT_CYC) @(posedge clk);
        $display("timeout, run still busy after %0d cycles", LIMIT_CYC);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/keypad_control_checker.sv
`default_nettype none

module keypad_control_checker
    import keypad_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input lines_t   scancol,
    input logic     msg_tx_ctrl,
    input message_t msg_1,
    input logic     commit_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench at the end of the run
    int assert_fails = 0;

    // exactly one column driven at any time
    a_col_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(scancol))
    else begin
        $error("scancol not one-hot: %b", scancol);
        assert_fails++;
    end

    // send is a single-cycle pulse
    a_tx_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        msg_tx_ctrl |=> !msg_tx_ctrl)
    else begin
        $error("msg_tx_ctrl high for two cycles");
        assert_fails++;
    end

    // message only moves right after a commit
    a_msg_commit: assert property (@(posedge clk) disable iff (!rst_n)
        (msg_1 != $past(msg_1)) |-> $past(commit_valid))
    else begin
        $error("msg_1 changed without a commit");
        assert_fails++;
    end

endmodule

bind keypad_control keypad_control_checker checker_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .scancol      (scancol),
    .msg_tx_ctrl  (msg_tx_ctrl),
    .msg_1        (msg_1),
    .commit_valid (commit_valid)
);

`default_nettype wire

//--- logic/keypad_control.sv
`default_nettype none

module keypad_control
    import keypad_pkg::*;
#(
    parameter int scan_ticks = SCAN_TICKS
) (
    input  logic     clk,
    input  logic     rst_n,
    input  lines_t   readrow,
    output lines_t   scancol,
    output logic     msg_tx_ctrl,
    output message_t msg_1
);

    logic        scan_tick;
    logic        sweep_done;
    keycode_t    sweep_code;
    logic        key_strobe;
    keycode_t    key_code;
    logic        commit_valid;
    keycode_t    commit_key;
    tap_t        commit_tap;
    logic        commit_upper;
    entry_mode_e commit_mode;

    // column dwell
    scan_timer #(
        .scan_ticks (scan_ticks)
    ) scan_timer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_tick (scan_tick)
    );

    keypad_scanner keypad_scanner_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_tick  (scan_tick),
        .readrow    (readrow),
        .scancol    (scancol),
        .sweep_done (sweep_done),
        .sweep_code (sweep_code)
    );

    key_debouncer key_debouncer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sweep_done (sweep_done),
        .sweep_code (sweep_code),
        .key_strobe (key_strobe),
        .key_code   (key_code)
    );

    // decides when a character is final
    multitap_control multitap_control_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_strobe   (key_strobe),
        .key_code     (key_code),
        .commit_valid (commit_valid),
        .commit_key   (commit_key),
        .commit_tap   (commit_tap),
        .commit_upper (commit_upper),
        .commit_mode  (commit_mode),
        .msg_tx_ctrl  (msg_tx_ctrl)
    );

    // decides which character it is
    message_assembler message_assembler_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .commit_valid (commit_valid),
        .commit_key   (commit_key),
        .commit_tap   (commit_tap),
        .commit_upper (commit_upper),
        .commit_mode  (commit_mode),
        .msg_1        (msg_1)
    );

endmodule

`default_nettype wire

//--- logic/message_assembler.sv
`default_nettype none

module message_assembler
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        commit_valid,
    input  keycode_t    commit_key,
    input  tap_t        commit_tap,
    input  logic        commit_upper,
    input  entry_mode_e commit_mode,
    output message_t    msg_1
);

    localparam int MSG_BITS = MSG_CHARS * 8;

    ascii_t new_char;

    // character for this commit
    always_comb begin
        if (commit_key == KEY_C) begin
            // C with nothing pending
            new_char = ASCII_SPACE;
        end else if (commit_mode == MODE_NUMBER) begin
            new_char = number_char(commit_key);
        end else begin
            new_char = letter_char(commit_key, commit_tap, commit_upper);
        end
    end

    // oldest character falls off the top byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msg_1 <= {MSG_CHARS{ASCII_SPACE}};
        end else if (commit_valid) begin
            msg_1 <= {msg_1[MSG_BITS-9:0], new_char};
        end
    end

endmodule

`default_nettype wire

//--- logic/multitap_control.sv
`default_nettype none

module multitap_control
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        key_strobe,
    input  keycode_t    key_code,
    output logic        commit_valid,
    output keycode_t    commit_key,
    output tap_t        commit_tap,
    output logic        commit_upper,
    output entry_mode_e commit_mode,
    output logic        msg_tx_ctrl
);

    entry_mode_e mode;
    logic        shift;
    keycode_t    pend_key;
    tap_t        pend_tap;
    logic        pending;
    logic        char_key;
    logic        tap_last;

    assign pending  = (pend_key != KEY_NONE);
    // control keys cycle through nothing
    assign char_key = (taps_for_key(key_code) != 3'd0);
    // last character of the pending key, next tap wraps
    assign tap_last = (pend_tap == tap_t'(taps_for_key(pend_key) - 3'd1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode         <= MODE_NUMBER;
            shift        <= 1'b0;
            pend_key     <= KEY_NONE;
            pend_tap     <= '0;
            commit_valid <= 1'b0;
            msg_tx_ctrl  <= 1'b0;
        end else begin
            commit_valid <= 1'b0;
            msg_tx_ctrl  <= 1'b0;
            if (key_strobe) begin
                case (key_code)
                    KEY_B: begin
                        // mode flip drops whatever was in progress
                        mode     <= (mode == MODE_NUMBER) ? MODE_LETTER : MODE_NUMBER;
                        shift    <= 1'b0;
                        pend_key <= KEY_NONE;
                    end
                    KEY_C: begin
                        // pending key or a plain space
                        commit_valid <= 1'b1;
                        pend_key     <= KEY_NONE;
                    end
                    KEY_D: begin
                        commit_valid <= pending;
                        pend_key     <= KEY_NONE;
                        msg_tx_ctrl  <= 1'b1;
                    end
                    KEY_HASH: begin
                        if (mode == MODE_LETTER) begin
                            shift <= ~shift;
                        end else begin
                            commit_valid <= 1'b1;
                        end
                    end
                    default: begin
                        // key A lands here and is ignored
                        if (char_key) begin
                            if (mode == MODE_NUMBER) begin
                                commit_valid <= 1'b1;
                            end else if (key_code == pend_key) begin
                                pend_tap <= tap_last ? '0 : pend_tap + 1'b1;
                            end else begin
                                // new key finalizes the old one
                                commit_valid <= pending;
                                pend_key     <= key_code;
                                pend_tap     <= '0;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // a pending key is always the one committed when there is one
    always_ff @(posedge clk) begin
        if (key_strobe) begin
            commit_key   <= pending ? pend_key : key_code;
            commit_tap   <= pending ? pend_tap : '0;
            commit_upper <= shift;
            commit_mode  <= mode;
        end
    end

endmodule

`default_nettype wire

//--- logic/key_debouncer.sv
`default_nettype none

module key_debouncer
    import keypad_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     sweep_done,
    input  keycode_t sweep_code,
    output logic     key_strobe,
    output keycode_t key_code
);

    localparam int CNT_W = $clog2(DEBOUNCE_SWEEPS + 1);

    keycode_t         last_code;
    logic [CNT_W-1:0] stable_cnt;
    logic [CNT_W-1:0] cnt_next;
    logic             released;
    logic             press;

    // run length of identical sweep codes, saturating
    always_comb begin
        if (sweep_code != last_code) begin
            cnt_next = CNT_W'(1);
        end else if (stable_cnt == CNT_W'(DEBOUNCE_SWEEPS)) begin
            cnt_next = stable_cnt;
        end else begin
            cnt_next = stable_cnt + 1'b1;
        end
    end

    // fires once on the sweep that makes the key stable
    assign press = released && (sweep_code != KEY_NONE) &&
                   (cnt_next == CNT_W'(DEBOUNCE_SWEEPS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_code  <= KEY_NONE;
            stable_cnt <= '0;
            released   <= 1'b1;
            key_strobe <= 1'b0;
        end else begin
            key_strobe <= 1'b0;
            if (sweep_done) begin
                last_code  <= sweep_code;
                stable_cnt <= cnt_next;
                if (sweep_code == KEY_NONE) begin
                    // an empty sweep arms the next press
                    released <= 1'b1;
                end else if (press) begin
                    released   <= 1'b0;
                    key_strobe <= 1'b1;
                end
            end
        end
    end

    // code travels with the strobe
    always_ff @(posedge clk) begin
        if (sweep_done && press) begin
            key_code <= sweep_code;
        end
    end

endmodule

`default_nettype wire

//--- logic/keypad_scanner.sv
`default_nettype none

module keypad_scanner
    import keypad_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     scan_tick,
    input  lines_t   readrow,
    output lines_t   scancol,
    output logic     sweep_done,
    output keycode_t sweep_code
);

    lines_t   row_meta;
    lines_t   row_sync;
    lines_t   row_low;
    keycode_t col_code;
    keycode_t hit_code;
    logic     last_col;

    // rows come straight from the switches
    // two flops before they are looked at
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_meta <= '0;
            row_sync <= '0;
        end else begin
            row_meta <= readrow;
            row_sync <= row_meta;
        end
    end

    // lowest row wins when several are down in one column
    assign row_low  = row_sync & (~row_sync + lines_t'(1));
    assign col_code = (row_sync != '0) ? {row_low, scancol} : KEY_NONE;
    assign last_col = scancol[3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scancol    <= 4'b0001;
            hit_code   <= KEY_NONE;
            sweep_done <= 1'b0;
            sweep_code <= KEY_NONE;
        end else begin
            sweep_done <= 1'b0;
            if (scan_tick) begin
                // sample first, then step to the next column
                scancol <= {scancol[2:0], scancol[3]};
                if (last_col) begin
                    // end of sweep, earlier column hit has priority
                    sweep_done <= 1'b1;
                    sweep_code <= (hit_code != KEY_NONE) ? hit_code : col_code;
                    hit_code   <= KEY_NONE;
                end else if (hit_code == KEY_NONE) begin
                    // keep only the first hit of the sweep
                    hit_code <= col_code;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/scan_timer.sv
`default_nettype none

module scan_timer
    import keypad_pkg::*;
#(
    parameter int scan_ticks = SCAN_TICKS
) (
    input  logic clk,
    input  logic rst_n,
    output logic scan_tick
);

    // at least one bit even for a period of one cycle
    localparam int CNT_W = (scan_ticks > 1) ? $clog2(scan_ticks) : 1;

    logic [CNT_W-1:0] tick_cnt;
    logic             at_last;

    // terminal count of the column dwell
    assign at_last   = (tick_cnt == CNT_W'(scan_ticks - 1));
    assign scan_tick = at_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (at_last) begin
            // wrap and start the next dwell
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    // timing and sizing
    localparam int SCAN_TICKS      = 100000;
    localparam int DEBOUNCE_SWEEPS = 2;
    localparam int MSG_CHARS       = 16;

    // one-hot row or column lines
    typedef logic [3:0]             lines_t;
    // row nibble above column nibble, zero means no key
    typedef logic [7:0]             keycode_t;
    typedef logic [7:0]             ascii_t;
    // newest character sits in the low byte
    typedef logic [MSG_CHARS*8-1:0] message_t;
    typedef logic [1:0]             tap_t;

    typedef enum logic {
        MODE_NUMBER,
        MODE_LETTER
    } entry_mode_e;

    localparam ascii_t ASCII_SPACE = 8'h20;

    // keypad layout, rows 1-2-3-A / 4-5-6-B / 7-8-9-C / *-0-#-D
    localparam keycode_t KEY_NONE = 8'h00;
    localparam keycode_t KEY_1    = 8'h11;
    localparam keycode_t KEY_2    = 8'h12;
    localparam keycode_t KEY_3    = 8'h14;
    localparam keycode_t KEY_A    = 8'h18;
    localparam keycode_t KEY_4    = 8'h21;
    localparam keycode_t KEY_5    = 8'h22;
    localparam keycode_t KEY_6    = 8'h24;
    localparam keycode_t KEY_B    = 8'h28;
    localparam keycode_t KEY_7    = 8'h41;
    localparam keycode_t KEY_8    = 8'h42;
    localparam keycode_t KEY_9    = 8'h44;
    localparam keycode_t KEY_C    = 8'h48;
    localparam keycode_t KEY_STAR = 8'h81;
    localparam keycode_t KEY_0    = 8'h82;
    localparam keycode_t KEY_HASH = 8'h84;
    localparam keycode_t KEY_D    = 8'h88;

    // characters a key cycles through in letter mode, 0 for control keys
    function automatic logic [2:0] taps_for_key(keycode_t key);
        case (key)
            KEY_1, KEY_7, KEY_9, KEY_STAR, KEY_0:        return 3'd4;
            KEY_2, KEY_3, KEY_4, KEY_5, KEY_6, KEY_8:    return 3'd3;
            default:                                     return 3'd0;
        endcase
    endfunction

    function automatic ascii_t letter_char(keycode_t key, tap_t tap, logic upper);
        logic [31:0] set;
        ascii_t      ch;
        // tap 0 is the leftmost character of each set
        case (key)
            KEY_1:    set = "@_&:";
            KEY_2:    set = "abc ";
            KEY_3:    set = "def ";
            KEY_4:    set = "ghi ";
            KEY_5:    set = "jkl ";
            KEY_6:    set = "mno ";
            KEY_7:    set = "pqrs";
            KEY_8:    set = "tuv ";
            KEY_9:    set = "wxyz";
            KEY_STAR: set = "+-/=";
            KEY_0:    set = ",.?!";
            default:  set = "    ";
        endcase
        ch = set[8*(3-tap) +: 8];
        // shift only touches letters, punctuation passes through
        if (upper && (ch >= "a") && (ch <= "z")) begin
            ch = ch - 8'h20;
        end
        return ch;
    endfunction

    // character printed on the key face
    function automatic ascii_t number_char(keycode_t key);
        case (key)
            KEY_1:    return "1";
            KEY_2:    return "2";
            KEY_3:    return "3";
            KEY_4:    return "4";
            KEY_5:    return "5";
            KEY_6:    return "6";
            KEY_7:    return "7";
            KEY_8:    return "8";
            KEY_9:    return "9";
            KEY_0:    return "0";
            KEY_STAR: return "*";
            KEY_HASH: return "#";
            default:  return ASCII_SPACE;
        endcase
    endfunction

endpackage

`default_nettype wire
